// ==== vlog.f ====
+incdir+src
src/soc_bus_pkg.sv
src/soc_irq_pkg.sv
src/rst_debounce.sv
src/bus_decode.sv
src/bus_slaves.sv
src/irq_ctrl.sv
src/bus_return.sv
src/soc_top.sv
sim/soc_props.sv
sim/tb_soc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the SoC bus testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_soc_top -f vlog.f > build.log 2>&1 &&
  { ./obj_dir/Vtb_soc_top > sim.log 2>&1 || true; } &&
  cat sim.log &&
  grep -q ">>> PASS" sim.log && ! grep -q ">>> FAIL" sim.log ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== sim/soc_patterns.txt ====
# name op(r/w) io word_adr wdat sel exp (all hex)
# exp is the read data for r, and the leds_o value after the access for w
rom_k00 r 0 7ff80 0000 3 00ff
rom_k05 r 0 7ff85 0000 3 05fa
rom_k2a r 0 7ffaa 0000 3 2ad5
rom_k7f r 0 7ffff 0000 3 7f80
dflt_io_low r 1 00010 0000 3 0000
dflt_io_near r 1 07882 0000 3 0000
gpio_sw r 1 07880 0000 3 00a5
led_wr_full w 1 07881 0a5c 3 0a5c
led_rd_full r 1 07881 0000 3 0a5c
led_wr_lo w 1 07881 ff33 1 0a33
led_rd_lo r 1 07881 0000 3 0a33
led_wr_hi w 1 07881 f7ee 2 0733
led_rd_hi r 1 07881 0000 3 f733
rom_wr w 0 7ff85 1234 3 0733
rom_k05_again r 0 7ff85 0000 3 05fa
dflt_io_wr w 1 00020 ffff 3 0733
gpio_sw_wr w 1 07880 ffff 3 0733
gpio_sw_again r 1 07880 0000 3 00a5

// ==== sim/tb_soc_top.sv ====
//**********************************************************
// SoC bus fabric testbench
// Pattern-driven bus accesses, RAM merge with random data,
// interrupt and NMI acknowledge vectors
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module tb_soc_top;

  import soc_bus_pkg::*;
  import soc_irq_pkg::*;

  localparam int ACK_LIMIT = 20;  // Cycles before an access counts as lost

  logic                  clk = 1'b0;
  logic                  rst_lck;
  logic                  cyc;
  logic                  stb;
  bus_req_s              req;
  logic                  ack;
  bus_dat_t              dat;
  logic [`SOC_SW_W-1:0]  sw;
  logic [`SOC_LED_W-1:0] leds;
  irq_vec_t              irq;
  logic                  intr;
  logic                  inta;
  logic                  nmia;

  int          n_mismatch = 0;
  int          n_other    = 0;
  logic [15:0] lfsr_q     = 16'd20552;
  bit          loaded     = 1'b0;  // Pattern file read

  string    pat_name [$];
  logic     pat_we   [$];
  logic     pat_io   [$];
  bus_adr_t pat_adr  [$];
  bus_dat_t pat_dat  [$];
  bus_sel_t pat_sel  [$];
  bus_dat_t pat_exp  [$];

  always #2 clk = ~clk;  // 4 ns period

  soc_top u_dut (
    .clk     (clk),
    .rst_lck (rst_lck),
    .cyc_i   (cyc),
    .stb_i   (stb),
    .req_i   (req),
    .ack_o   (ack),
    .dat_o   (dat),
    .sw_i    (sw),
    .leds_o  (leds),
    .irq_i   (irq),
    .intr_o  (intr),
    .inta_i  (inta),
    .nmia_i  (nmia)
  );

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[14:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic report_mismatch(input string name, input bus_dat_t exp, input bus_dat_t act);
    n_mismatch++;
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic load_patterns();
    int    fd;
    int    n_fields;
    int    f_io;
    int    f_adr;
    int    f_dat;
    int    f_sel;
    int    f_exp;
    string line;
    string name;
    string op;
    fd = $fopen("sim/soc_patterns.txt", "r");
    if (fd == 0) begin
      n_other++;
      $display("ERROR: cannot open sim/soc_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
          n_fields = $sscanf(line, "%s %s %h %h %h %h %h",
                             name, op, f_io, f_adr, f_dat, f_sel, f_exp);
          if (n_fields != 7) begin
            n_other++;
            $display("ERROR: unreadable pattern line: %s", line);
          end else begin
            pat_name.push_back(name);
            pat_we.push_back(op == "w");
            pat_io.push_back(f_io[0]);
            pat_adr.push_back(bus_adr_t'(f_adr));
            pat_dat.push_back(bus_dat_t'(f_dat));
            pat_sel.push_back(bus_sel_t'(f_sel));
            pat_exp.push_back(bus_dat_t'(f_exp));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One access, held until ack, then stb low for a cycle
  task automatic bus_access(input string name, input logic we, input logic io,
                            input bus_adr_t adr, input bus_dat_t wdat,
                            input bus_sel_t sel, output bus_dat_t rdat);
    int   waited;
    logic got;
    @(negedge clk);
    req.io  = io;
    req.adr = adr;
    req.dat = wdat;
    req.sel = sel;
    req.we  = we;
    cyc     = 1'b1;
    stb     = 1'b1;
    waited  = 0;
    got     = 1'b0;
    while (!got && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
      got = ack;
    end
    rdat = dat;
    cyc  = 1'b0;
    stb  = 1'b0;
    if (!got) begin
      n_other++;
      $display("ERROR: %s was not acknowledged within %0d cycles", name, ACK_LIMIT);
    end else if (waited != 3) begin
      n_mismatch++;
      $display("MISMATCH %s latency: expected 3, actual %0d", name, waited);
    end
  endtask

  task automatic run_patterns();
    bus_dat_t rdat;
    foreach (pat_name[i]) begin
      bus_access(pat_name[i], pat_we[i], pat_io[i], pat_adr[i], pat_dat[i], pat_sel[i], rdat);
      if (!pat_we[i] && rdat !== pat_exp[i]) begin
        report_mismatch(pat_name[i], pat_exp[i], rdat);
      end
      if (pat_we[i] && leds !== pat_exp[i][`SOC_LED_W-1:0]) begin
        report_mismatch({pat_name[i], " leds"},
                        bus_dat_t'(pat_exp[i][`SOC_LED_W-1:0]), bus_dat_t'(leds));
      end
    end
  endtask

  // Full write, then each select on an alias, read back on another alias
  task automatic ram_test();
    logic [15:0] bits;
    logic [7:0]  idx;
    logic [9:0]  hi_wr;
    logic [9:0]  hi_rd;
    bus_dat_t    model;
    bus_dat_t    wdat;
    bus_dat_t    rdat;
    bus_sel_t    sel;
    string       name;
    for (int it = 0; it < 6; it++) begin
      draw_bits(8, bits);
      idx = bits[7:0];
      draw_bits(10, bits);
      hi_wr = bits[9:0];
      draw_bits(16, model);
      bus_access($sformatf("ram%0d_init", it), 1'b1, 1'b0, {1'b0, hi_wr, idx},
                 model, 2'b11, rdat);
      for (int s = 0; s < 4; s++) begin
        sel = bus_sel_t'(s);
        draw_bits(10, bits);
        hi_wr = bits[9:0];
        draw_bits(10, bits);
        hi_rd = bits[9:0];
        draw_bits(16, wdat);
        name = $sformatf("ram%0d_sel%0d", it, s);
        bus_access(name, 1'b1, 1'b0, {1'b0, hi_wr, idx}, wdat, sel, rdat);
        if (sel[0]) model[7:0] = wdat[7:0];
        if (sel[1]) model[15:8] = wdat[15:8];
        bus_access(name, 1'b0, 1'b0, {1'b0, hi_rd, idx}, 16'h0000, 2'b11, rdat);
        if (rdat !== model) begin
          report_mismatch(name, model, rdat);
        end
      end
    end
  endtask

  task automatic irq_test();
    irq_vec_t pend;
    int       low;
    bus_dat_t exp;
    @(negedge clk);
    irq  = 8'b0110_0100;  // Lines 2, 5 and 6
    pend = irq;
    @(negedge clk);
    irq = '0;
    @(negedge clk);
    if (intr !== 1'b1) begin
      report_mismatch("irq_raise", 16'h0001, bus_dat_t'(intr));
    end
    while (pend != '0) begin
      low = 0;
      while (!pend[low]) low++;
      inta = 1'b1;
      @(negedge clk);
      exp = bus_dat_t'(`SOC_INTA_BASE + low);
      if (dat !== exp) begin
        report_mismatch($sformatf("inta_irq%0d", low), exp, dat);
      end
      pend[low] = 1'b0;
      inta      = 1'b0;
      @(negedge clk);
      if (intr !== (pend != '0)) begin
        report_mismatch($sformatf("intr_after_irq%0d", low),
                        bus_dat_t'(pend != '0), bus_dat_t'(intr));
      end
    end
  endtask

  task automatic nmi_test();
    @(negedge clk);
    nmia = 1'b1;
    @(negedge clk);
    if (dat !== `SOC_NMI_VECTOR) begin
      report_mismatch("nmi_vector", `SOC_NMI_VECTOR, dat);
    end
    inta = 1'b1;  // NMI still wins
    @(negedge clk);
    if (dat !== `SOC_NMI_VECTOR) begin
      report_mismatch("nmi_over_inta", `SOC_NMI_VECTOR, dat);
    end
    inta = 1'b0;
    nmia = 1'b0;
    @(negedge clk);
    if (intr !== 1'b0) begin
      report_mismatch("nmi_intr_quiet", 16'h0000, bus_dat_t'(intr));
    end
  endtask

  initial begin
    int   waited;
    logic got;
    rst_lck = 1'b0;
    cyc     = 1'b1;  // Request held through reset
    stb     = 1'b1;
    req     = '0;
    req.adr = 19'h7FF80;
    req.sel = 2'b11;
    sw      = 8'hA5;
    irq     = '0;
    inta    = 1'b0;
    nmia    = 1'b0;
    load_patterns();
    loaded = 1'b1;
    repeat (8) @(negedge clk);
    if (ack !== 1'b0) report_mismatch("reset_ack", 16'h0000, bus_dat_t'(ack));
    if (intr !== 1'b0) report_mismatch("reset_intr", 16'h0000, bus_dat_t'(intr));
    if (leds !== '0) report_mismatch("reset_leds", 16'h0000, bus_dat_t'(leds));
    rst_lck = 1'b1;
    waited  = 0;
    got     = 1'b0;
    while (!got && waited < `SOC_DEBOUNCE_CYCLES + ACK_LIMIT) begin
      @(negedge clk);
      waited++;
      got = ack;
    end
    if (!got) begin
      n_other++;
      $display("ERROR: request held through reset was never acknowledged");
    end else if (waited != `SOC_DEBOUNCE_CYCLES + 3) begin
      n_mismatch++;
      $display("MISMATCH reset_latency: expected %0d, actual %0d",
               `SOC_DEBOUNCE_CYCLES + 3, waited);
    end
    if (dat !== 16'h00FF) report_mismatch("reset_rom_k00", 16'h00FF, dat);
    cyc = 1'b0;
    stb = 1'b0;
    repeat (2) @(negedge clk);
    run_patterns();
    ram_test();
    irq_test();
    nmi_test();
    repeat (2) @(negedge clk);
    $display("Run complete: %0d mismatches, %0d other errors", n_mismatch, n_other);
    if (n_mismatch + n_other == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog sized from the pattern count
  initial begin
    int limit;
    wait (loaded);
    limit = 50 * pat_name.size() + 2000;
    repeat (limit) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles", limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/soc_props.sv ====
//**********************************************************
// Bus fabric properties
// Acknowledge timing and LED update rules on soc_top
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module soc_props (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire                     cyc_i,
  input  wire                     stb_i,
  input  soc_bus_pkg::slave_req_s dec_req_i,
  input  wire                     acc_vld_i,
  input  wire                     ack_i,
  input  wire [`SOC_LED_W-1:0]    leds_i
);

  import soc_bus_pkg::*;

  logic started_q = 1'b0;  // Low until the first edge
  logic open_q;            // Access accepted, ack still due
  logic accept;
  logic led_wr;

  // Master request seen while the fabric is idle and out of reset
  assign accept = cyc_i & stb_i & ~open_q & ~rst_i;

  // GPIO word 1 write sitting in the slave stage output
  assign led_wr = acc_vld_i & dec_req_i.req.we & (dec_req_i.id == SLV_GPIO) &
                  dec_req_i.req.adr[0];

  always_ff @(posedge clk) begin
    started_q <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      open_q <= 1'b0;
    end else if (accept) begin
      open_q <= 1'b1;
    end else if (ack_i) begin
      open_q <= 1'b0;
    end
  end

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
    !(ack_i && $past(ack_i))) else $error("ack_o high for two cycles");

  // Ack three edges after the accepting edge
  ack_latency: assert property (@(posedge clk) disable iff (rst_i)
    ack_i == $past(accept, 3)) else $error("ack_o not 3 cycles after acceptance");

  ack_in_reset: assert property (@(posedge clk)
    (started_q && rst_i) |-> !ack_i) else $error("ack_o high during reset");

  leds_on_write: assert property (@(posedge clk) disable iff (rst_i)
    (leds_i != $past(leds_i)) |-> led_wr) else $error("leds_o changed without a write");

endmodule

bind soc_top soc_props u_soc_props (
  .clk       (clk),
  .rst_i     (rst),
  .cyc_i     (cyc_i),
  .stb_i     (stb_i),
  .dec_req_i (dec_req),
  .acc_vld_i (acc_vld),
  .ack_i     (ack_o),
  .leds_i    (leds_o)
);

`default_nettype wire

// ==== src/soc_top.sv ====
//**********************************************************
// System bus fabric top level
// Decode, slave access and return pipeline, plus the reset
// debounce and the interrupt controller
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module soc_top (
  input  wire                   clk,
  input  wire                   rst_lck,
  input  wire                   cyc_i,
  input  wire                   stb_i,
  input  soc_bus_pkg::bus_req_s req_i,
  output logic                  ack_o,
  output soc_bus_pkg::bus_dat_t dat_o,
  input  wire [`SOC_SW_W-1:0]   sw_i,
  output logic [`SOC_LED_W-1:0] leds_o,
  input  soc_irq_pkg::irq_vec_t irq_i,
  output logic                  intr_o,
  input  wire                   inta_i,
  input  wire                   nmia_i
);

  import soc_bus_pkg::*;
  import soc_irq_pkg::*;

  logic       rst;      // Internal reset, active high
  logic       dec_vld;
  slave_req_s dec_req;
  logic       acc_vld;
  bus_dat_t   rd_dat;
  irq_id_t    irq_id;

  rst_debounce u_rst_debounce (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (rst)
  );

  bus_decode u_bus_decode (
    .clk       (clk),
    .rst_i     (rst),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .req_i     (req_i),
    .done_i    (ack_o),
    .dec_vld_o (dec_vld),
    .dec_req_o (dec_req)
  );

  bus_slaves u_bus_slaves (
    .clk       (clk),
    .rst_i     (rst),
    .dec_vld_i (dec_vld),
    .dec_req_i (dec_req),
    .sw_i      (sw_i),
    .leds_o    (leds_o),
    .acc_vld_o (acc_vld),
    .rd_dat_o  (rd_dat)
  );

  irq_ctrl u_irq_ctrl (
    .clk      (clk),
    .rst_i    (rst),
    .irq_i    (irq_i),
    .inta_i   (inta_i),
    .intr_o   (intr_o),
    .irq_id_o (irq_id)
  );

  bus_return u_bus_return (
    .clk       (clk),
    .rst_i     (rst),
    .acc_vld_i (acc_vld),
    .rd_dat_i  (rd_dat),
    .irq_id_i  (irq_id),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .ack_o     (ack_o),
    .dat_o     (dat_o)
  );

endmodule

`default_nettype wire

// ==== src/bus_return.sv ====
//**********************************************************
// Return stage
// Registered acknowledge and read data, NMI/INTA override
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module bus_return (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   acc_vld_i,
  input  soc_bus_pkg::bus_dat_t rd_dat_i,
  input  soc_irq_pkg::irq_id_t  irq_id_i,
  input  wire                   inta_i,
  input  wire                   nmia_i,
  output logic                  ack_o,
  output soc_bus_pkg::bus_dat_t dat_o
);

  import soc_bus_pkg::*;

  bus_dat_t dat_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= acc_vld_i;  // One-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (acc_vld_i) begin
      dat_q <= rd_dat_i;
    end
  end

  // NMI vector beats the interrupt vector
  always_comb begin
    if (nmia_i) begin
      dat_o = `SOC_NMI_VECTOR;
    end else if (inta_i) begin
      dat_o = `SOC_INTA_BASE + bus_dat_t'(irq_id_i);
    end else begin
      dat_o = dat_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/irq_ctrl.sv ====
//**********************************************************
// Simple priority interrupt controller
// Edge-captured pending bits, lowest index served first
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module irq_ctrl (
  input  wire                  clk,
  input  wire                  rst_i,
  input  soc_irq_pkg::irq_vec_t irq_i,
  input  wire                  inta_i,
  output logic                 intr_o,
  output soc_irq_pkg::irq_id_t irq_id_o
);

  import soc_irq_pkg::*;

  irq_vec_t   irq_prev_q;
  irq_vec_t   pend_q;
  irq_vec_t   clr_mask;
  irq_id_t    low_id;
  logic       serve;
  irq_state_e state_q;
  irq_state_e state_d;

  // Lowest pending index wins
  always_comb begin
    low_id = '0;
    for (int n = `SOC_IRQ_N - 1; n >= 0; n--) begin
      if (pend_q[n]) begin
        low_id = irq_id_t'(n);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    serve   = 1'b0;
    case (state_q)
      IRQ_IDLE, IRQ_PENDING: begin
        if (inta_i) begin  // Rising edge of inta
          serve   = 1'b1;
          state_d = IRQ_SERVING;
        end else begin
          state_d = (|pend_q) ? IRQ_PENDING : IRQ_IDLE;
        end
      end
      IRQ_SERVING: begin
        if (!inta_i) begin
          state_d = (|pend_q) ? IRQ_PENDING : IRQ_IDLE;
        end
      end
      default: state_d = IRQ_IDLE;
    endcase
  end

  assign clr_mask = serve ? (irq_vec_t'(1) << low_id) : '0;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_prev_q <= '0;
      pend_q     <= '0;
      irq_id_o   <= '0;
      state_q    <= IRQ_IDLE;
    end else begin
      irq_prev_q <= irq_i;
      pend_q     <= (pend_q & ~clr_mask) | (irq_i & ~irq_prev_q);  // New edges win
      state_q    <= state_d;
      if (serve) begin
        irq_id_o <= low_id;
      end
    end
  end

  assign intr_o = |pend_q;

endmodule

`default_nettype wire

// ==== src/bus_slaves.sv ====
//**********************************************************
// Slave access stage
// Boot ROM, base RAM, switch/LED GPIO and the default slave
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module bus_slaves (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire                     dec_vld_i,
  input  soc_bus_pkg::slave_req_s dec_req_i,
  input  wire [`SOC_SW_W-1:0]     sw_i,
  output logic [`SOC_LED_W-1:0]   leds_o,
  output logic                    acc_vld_o,
  output soc_bus_pkg::bus_dat_t   rd_dat_o
);

  import soc_bus_pkg::*;

  bus_req_s               req;
  logic [`SOC_RAM_AW-1:0] ram_idx;
  logic [`SOC_ROM_AW-1:0] rom_idx;
  logic                   ram_wr;
  logic                   led_wr;
  bus_dat_t               rom_word;
  bus_dat_t               reg_rd_d;
  bus_dat_t               ram_mem [2**`SOC_RAM_AW];
  bus_dat_t               ram_rd_q;
  bus_dat_t               reg_rd_q;
  bus_dat_t               led_q;
  logic                   ram_sel_q;

  assign req      = dec_req_i.req;
  assign ram_idx  = req.adr[`SOC_RAM_AW-1:0];
  assign rom_idx  = req.adr[`SOC_ROM_AW-1:0];
  assign ram_wr   = dec_vld_i & req.we & (dec_req_i.id == SLV_RAM);
  assign led_wr   = dec_vld_i & req.we & (dec_req_i.id == SLV_GPIO) & req.adr[0];

  // Computed ROM, index in the high byte and its complement below
  assign rom_word = {8'(rom_idx), ~8'(rom_idx)};

  always_comb begin
    case (dec_req_i.id)
      SLV_ROM:  reg_rd_d = rom_word;
      SLV_GPIO: reg_rd_d = req.adr[0] ? led_q : bus_dat_t'(sw_i);
      default:  reg_rd_d = '0;  // Default slave, RAM comes from ram_rd_q
    endcase
  end

  // Base RAM with byte selects
  always_ff @(posedge clk) begin
    if (ram_wr) begin
      for (int b = 0; b < `SOC_SEL_W; b++) begin
        if (req.sel[b]) begin
          ram_mem[ram_idx][8*b +: 8] <= req.dat[8*b +: 8];
        end
      end
    end
    if (dec_vld_i) begin
      ram_rd_q <= ram_mem[ram_idx];
    end
  end

  // LED register, GPIO word 1
  always_ff @(posedge clk) begin
    if (rst_i) begin
      led_q <= '0;
    end else if (led_wr) begin
      for (int b = 0; b < `SOC_SEL_W; b++) begin
        if (req.sel[b]) begin
          led_q[8*b +: 8] <= req.dat[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_vld_i) begin
      reg_rd_q  <= reg_rd_d;
      ram_sel_q <= (dec_req_i.id == SLV_RAM);
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      acc_vld_o <= 1'b0;
    end else begin
      acc_vld_o <= dec_vld_i;
    end
  end

  assign rd_dat_o = ram_sel_q ? ram_rd_q : reg_rd_q;
  assign leds_o   = led_q[`SOC_LED_W-1:0];

endmodule

`default_nettype wire

// ==== src/bus_decode.sv ====
//**********************************************************
// Bus decode stage
// Accepts one request at a time and tags it with its slave
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module bus_decode (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire                     cyc_i,
  input  wire                     stb_i,
  input  soc_bus_pkg::bus_req_s   req_i,
  input  wire                     done_i,
  output logic                    dec_vld_o,
  output soc_bus_pkg::slave_req_s dec_req_o
);

  import soc_bus_pkg::*;

  logic [`SOC_ADR_W:0] key;  // {io, adr}
  logic                busy_q;
  logic                accept;
  slave_id_e           id_d;

  assign key    = {req_i.io, req_i.adr};
  assign accept = cyc_i & stb_i & ~busy_q;

  // Windows in priority order
  always_comb begin
    if ((key & `SOC_ROM_MASK) == `SOC_ROM_MATCH) begin
      id_d = SLV_ROM;
    end else if ((key & `SOC_GPIO_MASK) == `SOC_GPIO_MATCH) begin
      id_d = SLV_GPIO;
    end else if (!req_i.io) begin
      id_d = SLV_RAM;  // Any other memory access
    end else begin
      id_d = SLV_DEFAULT;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      dec_vld_o <= 1'b0;
    end else begin
      dec_vld_o <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;  // Ack seen, strobe may be reused
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec_req_o.req <= req_i;
      dec_req_o.id  <= id_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/rst_debounce.sv ====
//**********************************************************
// Reset debounce
// Holds the internal reset for a fixed count after release
//**********************************************************
`timescale 1ns/100ps
`default_nettype none

`include "soc_consts.svh"

module rst_debounce (
  input  wire  clk,
  input  wire  rst_lck,
  output logic rst_o
);

  localparam int CNT_W = $clog2(`SOC_DEBOUNCE_CYCLES + 1);

  // Starts loaded, so reset is also held from power-on
  logic [CNT_W-1:0] cnt_q = CNT_W'(`SOC_DEBOUNCE_CYCLES);

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q <= CNT_W'(`SOC_DEBOUNCE_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign rst_o = (cnt_q != '0);

endmodule

`default_nettype wire

// ==== src/soc_irq_pkg.sv ====
//**********************************************************
// Interrupt controller types
//**********************************************************
`default_nettype none

`include "soc_consts.svh"

package soc_irq_pkg;

  typedef logic [`SOC_IRQ_N-1:0]         irq_vec_t;
  typedef logic [$clog2(`SOC_IRQ_N)-1:0] irq_id_t;

  // Acknowledge sequence
  typedef enum logic [1:0] {
    IRQ_IDLE,     // Nothing pending
    IRQ_PENDING,  // Waiting for inta
    IRQ_SERVING   // Id latched, waiting for inta to drop
  } irq_state_e;

endpackage

`default_nettype wire

// ==== src/soc_bus_pkg.sv ====
//**********************************************************
// System bus types
// Request and decoded request structs, slave ids
//**********************************************************
`default_nettype none

`include "soc_consts.svh"

package soc_bus_pkg;

  typedef logic [`SOC_ADR_W-1:0] bus_adr_t;  // Word address
  typedef logic [`SOC_DAT_W-1:0] bus_dat_t;
  typedef logic [`SOC_SEL_W-1:0] bus_sel_t;  // One bit per byte

  typedef struct packed {
    logic     io;   // I/O space tag
    bus_adr_t adr;
    bus_dat_t dat;  // Write data
    bus_sel_t sel;
    logic     we;
  } bus_req_s;

  typedef enum logic [1:0] {
    SLV_ROM,
    SLV_GPIO,
    SLV_RAM,
    SLV_DEFAULT
  } slave_id_e;

  typedef struct packed {
    bus_req_s  req;
    slave_id_e id;
  } slave_req_s;

endpackage

`default_nettype wire

// ==== src/soc_consts.svh ====
//**********************************************************
// SoC constants
// Bus widths, decode windows, acknowledge vectors and the
// reset hold length of the system bus fabric
//**********************************************************
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define SOC_DAT_W 16
`define SOC_ADR_W 19
`define SOC_SEL_W 2

// Windows, compared on {io tag, word address}
`define SOC_ROM_MATCH  20'h7FF80  // mem 0xFFF00 - 0xFFFFF
`define SOC_ROM_MASK   20'hFFF80
`define SOC_GPIO_MATCH 20'h87880  // io 0xF100 - 0xF103
`define SOC_GPIO_MASK  20'h87FFE

`define SOC_ROM_AW 7              // 128 words
`define SOC_RAM_AW 8              // Aliases over all of memory

// GPIO pins
`define SOC_SW_W  8
`define SOC_LED_W 12

// Interrupts
`define SOC_NMI_VECTOR 16'h0002
`define SOC_INTA_BASE  16'h0008
`define SOC_IRQ_N      8

`define SOC_DEBOUNCE_CYCLES 16

`endif
